// File: filelist.f
+incdir+verif
hdl/quad_pkg.sv
hdl/quad_job_ctrl.sv
hdl/pixel_prefetch_fifo.sv
hdl/kernel_weight_table.sv
hdl/conv_engine.sv
hdl/cnn_quad_top.sv
verif/tb_cnn_quad.sv

// File: hdl/cnn_quad_top.sv
`timescale 1ns/1ps

module cnn_quad_top (
    input  logic                   clk_core,
    input  logic                   rst,
    input  logic                   job_start,
    input  quad_pkg::job_cfg_t     job_cfg,
    output logic                   job_accept,
    output logic                   job_fetch_request,
    input  logic                   job_fetch_ack,
    output logic                   job_complete,
    input  logic                   job_complete_ack,
    input  logic                   pixel_valid,
    output logic                   pixel_ready,
    input  quad_pkg::pixel_word_t  pixel_data,
    input  logic                   weight_valid,
    output logic                   weight_ready,
    input  quad_pkg::weight_word_t weight_data,
    output logic                   result_valid,
    input  logic                   result_ready,
    output quad_pkg::result_t      result
);
    import quad_pkg::*;

    job_cfg_t                    active_cfg;
    logic                        job_active;
    logic                        job_done;
    logic                        fifo_full;
    logic                        fifo_push;
    logic                        fifo_empty;
    logic                        fifo_pop;
    pixel_word_t                 fifo_head;
    logic [KERNEL_IDX_WIDTH-1:0] rd_kernel;
    weight_word_t                rd_weights;
    logic [KERNEL_CNT_WIDTH-1:0] num_kernels;

    quad_job_ctrl i_quad_job_ctrl (
        .clk_core          (clk_core),
        .rst               (rst),
        .job_start         (job_start),
        .job_cfg           (job_cfg),
        .job_accept        (job_accept),
        .job_fetch_request (job_fetch_request),
        .job_fetch_ack     (job_fetch_ack),
        .pixel_valid       (pixel_valid),
        .pixel_ready       (pixel_ready),
        .fifo_full         (fifo_full),
        .fifo_push         (fifo_push),
        .job_done          (job_done),
        .job_complete      (job_complete),
        .job_complete_ack  (job_complete_ack),
        .active_cfg        (active_cfg),
        .job_active        (job_active)
    );

    pixel_prefetch_fifo i_pixel_prefetch_fifo (
        .clk_core  (clk_core),
        .rst       (rst),
        .push      (fifo_push),
        .push_data (pixel_data),
        .full      (fifo_full),
        .pop       (fifo_pop),
        .head      (fifo_head),
        .empty     (fifo_empty)
    );

    kernel_weight_table i_kernel_weight_table (
        .clk_core     (clk_core),
        .rst          (rst),
        .job_active   (job_active),
        .weight_valid (weight_valid),
        .weight_ready (weight_ready),
        .weight_data  (weight_data),
        .rd_kernel    (rd_kernel),
        .rd_weights   (rd_weights),
        .num_kernels  (num_kernels)
    );

    conv_engine i_conv_engine (
        .clk_core     (clk_core),
        .rst          (rst),
        .cfg          (active_cfg),
        .job_active   (job_active),
        .fifo_head    (fifo_head),
        .fifo_empty   (fifo_empty),
        .fifo_pop     (fifo_pop),
        .rd_kernel    (rd_kernel),
        .rd_weights   (rd_weights),
        .num_kernels  (num_kernels),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result),
        .job_done     (job_done)
    );

endmodule

// File: hdl/conv_engine.sv
`timescale 1ns/1ps

module conv_engine (
    input  logic                                  clk_core,
    input  logic                                  rst,
    input  quad_pkg::job_cfg_t                    cfg,
    input  logic                                  job_active,
    input  quad_pkg::pixel_word_t                 fifo_head,
    input  logic                                  fifo_empty,
    output logic                                  fifo_pop,
    output logic [quad_pkg::KERNEL_IDX_WIDTH-1:0] rd_kernel,
    input  quad_pkg::weight_word_t                rd_weights,
    input  logic [quad_pkg::KERNEL_CNT_WIDTH-1:0] num_kernels,
    output logic                                  result_valid,
    input  logic                                  result_ready,
    output quad_pkg::result_t                     result,
    output logic                                  job_done
);
    import quad_pkg::*;

    logic                        stall;
    logic                        feed;
    logic                        last_k;
    logic                        accept;
    pixel_word_t                 relu_pix;
    logic                        s1_valid;
    pixel_word_t                 s1_pix;
    weight_word_t                s1_wts;
    logic                        s2_valid;
    logic signed [PROD_WIDTH-1:0] s2_prod [NUM_LANES];
    logic signed [ACC_WIDTH-1:0] tree_sum;
    logic signed [ACC_WIDTH-1:0] acc_q;
    logic [KERNEL_IDX_WIDTH-1:0] out_kernel;
    logic [DIM_WIDTH-1:0]        out_col;
    logic [DIM_WIDTH-1:0]        out_row;
    logic                        out_last_k;
    logic                        out_last_col;
    logic                        out_last_row;

    // Held result freezes every stage
    assign stall    = result_valid && !result_ready;
    assign feed     = job_active && !fifo_empty && (num_kernels != '0) && !stall;
    assign last_k   = ({1'b0, rd_kernel} == num_kernels - 1'b1);
    assign fifo_pop = feed && last_k;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (cfg.relu_en && fifo_head[i][PIXEL_WIDTH-1]) begin
                relu_pix[i] = '0;
            end else begin
                relu_pix[i] = fifo_head[i];
            end
        end
    end

    always_comb begin
        tree_sum = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            tree_sum = tree_sum + ACC_WIDTH'(s2_prod[i]);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Three-stage multiply-accumulate pipeline
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_core) begin
        if (rst) begin
            rd_kernel    <= '0;
            s1_valid     <= 1'b0;
            s2_valid     <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            if (!job_active) begin
                rd_kernel <= '0;
            end else if (feed) begin
                rd_kernel <= last_k ? '0 : rd_kernel + 1'b1;
            end
            if (!stall) begin
                s1_valid     <= feed;
                s2_valid     <= s1_valid;
                result_valid <= s2_valid;
            end
        end
    end

    always_ff @(posedge clk_core) begin
        if (!stall) begin
            s1_pix <= relu_pix;
            s1_wts <= rd_weights;
            for (int i = 0; i < NUM_LANES; i++) begin
                s2_prod[i] <= PROD_WIDTH'(s1_pix[i]) * PROD_WIDTH'(s1_wts[i]);
            end
            acc_q <= tree_sum;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output position, kernel fastest then column then row
    ////////////////////////////////////////////////////////////////////////////

    assign accept       = result_valid && result_ready;
    assign out_last_k   = ({1'b0, out_kernel} == num_kernels - 1'b1);
    assign out_last_col = (out_col == cfg.num_cols - 1'b1);
    assign out_last_row = (out_row == cfg.num_rows - 1'b1);
    assign job_done     = accept && out_last_k && out_last_col && out_last_row;

    assign result = '{value: acc_q, row: out_row, col: out_col, kernel: out_kernel};

    always_ff @(posedge clk_core) begin
        if (rst || !job_active) begin
            out_kernel <= '0;
            out_col    <= '0;
            out_row    <= '0;
        end else if (accept) begin
            out_kernel <= out_last_k ? '0 : out_kernel + 1'b1;
            if (out_last_k) begin
                out_col <= out_last_col ? '0 : out_col + 1'b1;
                if (out_last_col) begin
                    out_row <= out_last_row ? '0 : out_row + 1'b1;
                end
            end
        end
    end

endmodule

// File: hdl/kernel_weight_table.sv
`timescale 1ns/1ps

module kernel_weight_table (
    input  logic                                  clk_core,
    input  logic                                  rst,
    input  logic                                  job_active,
    input  logic                                  weight_valid,
    output logic                                  weight_ready,
    input  quad_pkg::weight_word_t                weight_data,
    input  logic [quad_pkg::KERNEL_IDX_WIDTH-1:0] rd_kernel,
    output quad_pkg::weight_word_t                rd_weights,
    output logic [quad_pkg::KERNEL_CNT_WIDTH-1:0] num_kernels
);
    import quad_pkg::*;

    weight_word_t                wt_mem [MAX_KERNELS];
    logic                        load;
    logic                        job_seen;
    logic                        has_room;
    logic [KERNEL_IDX_WIDTH-1:0] wr_idx;

    assign weight_ready = !job_active;
    assign load         = weight_valid && weight_ready;
    assign has_room     = num_kernels < KERNEL_CNT_WIDTH'(MAX_KERNELS);

    // First word after a job restarts the set at entry 0
    assign wr_idx = job_seen ? '0 : num_kernels[KERNEL_IDX_WIDTH-1:0];

    assign rd_weights = wt_mem[rd_kernel];

    always_ff @(posedge clk_core) begin
        if (load && (job_seen || has_room)) begin
            wt_mem[wr_idx] <= weight_data;
        end
    end

    always_ff @(posedge clk_core) begin
        if (rst) begin
            num_kernels <= '0;
            job_seen    <= 1'b0;
        end else begin
            if (job_active) begin
                job_seen <= 1'b1;
            end else if (load) begin
                job_seen <= 1'b0;
            end
            if (load && job_seen) begin
                num_kernels <= KERNEL_CNT_WIDTH'(1);
            end else if (load && has_room) begin
                num_kernels <= num_kernels + 1'b1;
            end
        end
    end

endmodule

// File: hdl/pixel_prefetch_fifo.sv
`timescale 1ns/1ps

module pixel_prefetch_fifo (
    input  logic                  clk_core,
    input  logic                  rst,
    input  logic                  push,
    input  quad_pkg::pixel_word_t push_data,
    output logic                  full,
    input  logic                  pop,
    output quad_pkg::pixel_word_t head,
    output logic                  empty
);
    import quad_pkg::*;

    pixel_word_t                mem [FIFO_DEPTH];
    logic [FIFO_ADDR_WIDTH-1:0] wr_ptr;
    logic [FIFO_ADDR_WIDTH-1:0] rd_ptr;
    logic [FIFO_CNT_WIDTH-1:0]  count;
    logic                       do_push;
    logic                       do_pop;

    assign full    = (count == FIFO_CNT_WIDTH'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Show-ahead read
    assign head = mem[rd_ptr];

    always_ff @(posedge clk_core) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk_core) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Occupancy, unchanged on simultaneous push and pop
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hdl/quad_job_ctrl.sv
`timescale 1ns/1ps

module quad_job_ctrl (
    input  logic               clk_core,
    input  logic               rst,
    input  logic               job_start,
    input  quad_pkg::job_cfg_t job_cfg,
    output logic               job_accept,
    output logic               job_fetch_request,
    input  logic               job_fetch_ack,
    input  logic               pixel_valid,
    output logic               pixel_ready,
    input  logic               fifo_full,
    output logic               fifo_push,
    input  logic               job_done,
    output logic               job_complete,
    input  logic               job_complete_ack,
    output quad_pkg::job_cfg_t active_cfg,
    output logic               job_active
);
    import quad_pkg::*;

    ctrl_state_t          state;
    logic [DIM_WIDTH-1:0] row_cnt;
    logic [DIM_WIDTH-1:0] col_cnt;
    logic                 last_col;
    logic                 last_row;

    // Pixels admitted only during a row and while the buffer has room
    assign pixel_ready = (state == ST_ROW_STREAM) && !fifo_full;
    assign fifo_push   = pixel_valid && pixel_ready;
    assign job_active  = (state != ST_IDLE);

    assign last_col = (col_cnt == active_cfg.num_cols - 1'b1);
    assign last_row = (row_cnt == active_cfg.num_rows - 1'b1);

    always_ff @(posedge clk_core) begin
        if (state == ST_IDLE && job_start) begin
            active_cfg <= job_cfg;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Job state machine
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_core) begin
        if (rst) begin
            state             <= ST_IDLE;
            job_accept        <= 1'b0;
            job_fetch_request <= 1'b0;
            job_complete      <= 1'b0;
            row_cnt           <= '0;
            col_cnt           <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        state      <= ST_ACCEPT;
                    end
                end
                ST_ACCEPT: begin
                    if (!job_start) begin
                        job_accept <= 1'b0;
                        row_cnt    <= '0;
                        col_cnt    <= '0;
                        state      <= ST_FETCH_REQ;
                    end
                end
                ST_FETCH_REQ: begin
                    // Raise the request, drop it once acked
                    if (!job_fetch_request) begin
                        job_fetch_request <= !job_fetch_ack;
                    end else if (job_fetch_ack) begin
                        job_fetch_request <= 1'b0;
                        state             <= ST_FETCH_ACK;
                    end
                end
                ST_FETCH_ACK: begin
                    if (!job_fetch_ack) begin
                        state <= ST_ROW_STREAM;
                    end
                end
                ST_ROW_STREAM: begin
                    if (fifo_push) begin
                        if (last_col) begin
                            col_cnt <= '0;
                            if (last_row) begin
                                state <= ST_WAIT_DONE;
                            end else begin
                                row_cnt <= row_cnt + 1'b1;
                                state   <= ST_FETCH_REQ;
                            end
                        end else begin
                            col_cnt <= col_cnt + 1'b1;
                        end
                    end
                end
                ST_WAIT_DONE: begin
                    if (job_done) begin
                        job_complete <= 1'b1;
                        state        <= ST_COMPLETE;
                    end
                end
                ST_COMPLETE: begin
                    if (job_complete && job_complete_ack) begin
                        job_complete <= 1'b0;
                    end else if (!job_complete && !job_complete_ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: hdl/quad_pkg.sv
package quad_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath widths and limits
    ////////////////////////////////////////////////////////////////////////////

    localparam int NUM_LANES        = 8;
    localparam int PIXEL_WIDTH      = 8;
    localparam int WEIGHT_WIDTH     = 8;
    localparam int ACC_WIDTH        = 20;
    localparam int PROD_WIDTH       = PIXEL_WIDTH + WEIGHT_WIDTH;
    localparam int MAX_KERNELS      = 4;
    localparam int KERNEL_IDX_WIDTH = 2;
    localparam int KERNEL_CNT_WIDTH = KERNEL_IDX_WIDTH + 1;
    localparam int DIM_WIDTH        = 8;

    // Prefetch buffer, power-of-two depth so the pointers wrap by themselves
    localparam int FIFO_DEPTH       = 16;
    localparam int FIFO_ADDR_WIDTH  = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_WIDTH   = FIFO_ADDR_WIDTH + 1;

    ////////////////////////////////////////////////////////////////////////////
    // Data words and records
    ////////////////////////////////////////////////////////////////////////////

    typedef logic signed [PIXEL_WIDTH-1:0]  pixel_t;
    typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;

    typedef pixel_t  [NUM_LANES-1:0] pixel_word_t;
    typedef weight_t [NUM_LANES-1:0] weight_word_t;

    typedef struct packed {
        logic [DIM_WIDTH-1:0] num_rows;
        logic [DIM_WIDTH-1:0] num_cols;
        logic                 relu_en;
    } job_cfg_t;

    typedef struct packed {
        logic signed [ACC_WIDTH-1:0] value;
        logic [DIM_WIDTH-1:0]        row;
        logic [DIM_WIDTH-1:0]        col;
        logic [KERNEL_IDX_WIDTH-1:0] kernel;
    } result_t;

    // Job controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ACCEPT,
        ST_FETCH_REQ,
        ST_FETCH_ACK,
        ST_ROW_STREAM,
        ST_WAIT_DONE,
        ST_COMPLETE
    } ctrl_state_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator; exits non-zero on failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_cnn_quad -f filelist.f -o sim_cnn_quad \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_cnn_quad > sim.log 2>&1
cat sim.log

grep -q "TB FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

// File: verif/tb_quad_model.svh
`ifndef TB_QUAD_MODEL_SVH
`define TB_QUAD_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////////////////////

// Dot product of one pixel word with one kernel, ReLU applied per lane first
function automatic logic signed [ACC_WIDTH-1:0] ref_dot(
    input pixel_word_t  pix,
    input weight_word_t wts,
    input logic         relu
);
    int sum;
    int p;
    sum = 0;
    for (int i = 0; i < NUM_LANES; i++) begin
        p = int'(pix[i]);
        if (relu && p < 0) begin
            p = 0;
        end
        sum = sum + p * int'(wts[i]);
    end
    return ACC_WIDTH'(sum);
endfunction

// Kernel fastest, then column, then row
task automatic build_expected(input int rows, input int cols, input int nk, input logic relu);
    result_t exp_r;
    for (int r = 0; r < rows; r++) begin
        for (int c = 0; c < cols; c++) begin
            for (int k = 0; k < nk; k++) begin
                exp_r.value  = ref_dot(pix_mem[r][c], wt_set[k], relu);
                exp_r.row    = DIM_WIDTH'(r);
                exp_r.col    = DIM_WIDTH'(c);
                exp_r.kernel = KERNEL_IDX_WIDTH'(k);
                exp_q.push_back(exp_r);
            end
        end
    end
endtask

////////////////////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////////////////////

task automatic check_result(input result_t act, input result_t exp_r);
    if (act !== exp_r) begin
        $display(
            "ERROR t=%0t result: got v=%0d r=%0d c=%0d k=%0d, expected v=%0d r=%0d c=%0d k=%0d",
            $time, $signed(act.value), act.row, act.col, act.kernel,
            $signed(exp_r.value), exp_r.row, exp_r.col, exp_r.kernel);
        errors++;
    end
endtask

task automatic check_bit(input string name, input logic act, input logic exp_b);
    if (act !== exp_b) begin
        $display("ERROR t=%0t %s: got %b, expected %b", $time, name, act, exp_b);
        errors++;
    end
endtask

`endif

// File: verif/tb_cnn_quad.sv
`timescale 1ns/1ps

module tb_cnn_quad;
    import quad_pkg::*;

    localparam int SEED         = 94330;
    localparam int TIMEOUT      = 4000;
    localparam int MAX_ROWS     = 4;
    localparam int MAX_COLS     = 10;
    localparam int PIPE_DEPTH   = 3;
    localparam int SIG_ACCEPT   = 0;
    localparam int SIG_FETCH    = 1;
    localparam int SIG_COMPLETE = 2;
    localparam int SIG_WREADY   = 3;

    logic         clk_core;
    logic         rst;
    logic         job_start;
    job_cfg_t     job_cfg;
    logic         job_accept;
    logic         job_fetch_request;
    logic         job_fetch_ack;
    logic         job_complete;
    logic         job_complete_ack;
    logic         pixel_valid;
    logic         pixel_ready;
    pixel_word_t  pixel_data;
    logic         weight_valid;
    logic         weight_ready;
    weight_word_t weight_data;
    logic         result_valid;
    logic         result_ready;
    result_t      result;

    pixel_word_t  pix_mem [MAX_ROWS][MAX_COLS];
    weight_word_t wt_set  [MAX_KERNELS];
    result_t      exp_q [$];
    result_t      want_r;
    int           errors;
    int           checked;
    int           tests_run;
    int           fetch_rises;
    int           full_cycles;
    int           pix_in;
    int           res_out;
    int           cur_nk;
    logic         fetch_prev = 1'b0;
    logic         rand_ready;
    logic         timed_out;
    time          hold_until;

    `include "tb_quad_model.svh"

    cnn_quad_top i_cnn_quad_top (.*);

    always #10 clk_core = ~clk_core;

    // Result back-pressure, held low for a window and then random
    initial begin
        result_ready = 1'b1;
        forever begin
            @(posedge clk_core);
            #2;
            if ($time < hold_until) begin
                result_ready = 1'b0;
            end else if (rand_ready) begin
                result_ready = 1'($urandom % 2);
            end else begin
                result_ready = 1'b1;
            end
        end
    end

    // Words pushed minus the most words the engine can have popped
    function automatic logic fifo_must_be_full(input int pushes, input int results,
                                               input int nk);
        return (pushes - (results + PIPE_DEPTH) / nk) >= FIFO_DEPTH;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checker and monitors, sampled mid-cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk_core) begin
        if (result_valid && result_ready) begin
            if (exp_q.size() == 0) begin
                $display("t=%0t a result was accepted while none was expected", $time);
                errors++;
            end else begin
                want_r = exp_q.pop_front();
                check_result(result, want_r);
                checked++;
            end
        end
        if (job_fetch_request && !fetch_prev) begin
            fetch_rises++;
        end
        fetch_prev = job_fetch_request;
        if (fifo_must_be_full(pix_in, res_out, cur_nk)) begin
            full_cycles++;
            if (pixel_ready) begin
                $display("t=%0t pixel_ready is high while the prefetch FIFO must be full",
                         $time);
                errors++;
            end
        end
        // Transfers that complete at the coming rising edge
        if (pixel_valid && pixel_ready) begin
            pix_in++;
        end
        if (result_valid && result_ready) begin
            res_out++;
        end
        if (job_complete && exp_q.size() != 0) begin
            $display("t=%0t job_complete is high with %0d results missing", $time, exp_q.size());
            errors++;
        end
    end

    function automatic logic read_handshake(input int sel);
        case (sel)
            SIG_ACCEPT:   return job_accept;
            SIG_FETCH:    return job_fetch_request;
            SIG_COMPLETE: return job_complete;
            default:      return weight_ready;
        endcase
    endfunction

    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk_core);
            #2;
        end
    endtask

    task automatic wait_for(input int sel, input logic level, input string what);
        int   n;
        logic hit;
        n = 0;
        hit = 1'b0;
        while (!hit && !timed_out) begin
            @(negedge clk_core);
            hit = (read_handshake(sel) === level);
            step(1);
            n++;
            if (!hit && n >= TIMEOUT) begin
                $display("t=%0t timed out waiting for %s", $time, what);
                timed_out = 1'b1;
                errors++;
            end
        end
    endtask

    task automatic send_weight(input weight_word_t word);
        int   n;
        logic sent;
        n = 0;
        sent = 1'b0;
        weight_data = word;
        weight_valid = 1'b1;
        while (!sent && !timed_out) begin
            @(negedge clk_core);
            sent = weight_valid && weight_ready;
            step(1);
            n++;
            if (!sent && n >= TIMEOUT) begin
                $display("t=%0t timed out loading a weight word", $time);
                timed_out = 1'b1;
                errors++;
            end
        end
        weight_valid = 1'b0;
    endtask

    task automatic send_pixel(input pixel_word_t word, input logic rand_valid);
        int   n;
        logic sent;
        n = 0;
        sent = 1'b0;
        pixel_data = word;
        while (!sent && !timed_out) begin
            pixel_valid = rand_valid ? ($urandom % 3 != 0) : 1'b1;
            @(negedge clk_core);
            sent = pixel_valid && pixel_ready;
            step(1);
            n++;
            if (!sent && n >= TIMEOUT) begin
                $display("t=%0t timed out sending a pixel word", $time);
                timed_out = 1'b1;
                errors++;
            end
        end
    endtask

    // Random pixels and weights, optionally forcing even lanes negative
    task automatic make_data(input int rows, input int cols, input int nk, input logic neg);
        for (int k = 0; k < nk; k++) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                wt_set[k][i] = WEIGHT_WIDTH'($urandom);
            end
        end
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < cols; c++) begin
                for (int i = 0; i < NUM_LANES; i++) begin
                    pix_mem[r][c][i] = PIXEL_WIDTH'($urandom);
                    if (neg && i % 2 == 0) begin
                        pix_mem[r][c][i][PIXEL_WIDTH-1] = 1'b1;
                    end
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One job from weight load to completion
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_job(input string name, input int rows, input int cols, input int nk,
                           input logic relu, input logic neg, input logic stress);
        int       err0;
        int       chk0;
        int       fetch0;
        int       full0;
        job_cfg_t cfg;
        err0 = errors;
        chk0 = checked;
        make_data(rows, cols, nk, neg);
        wait_for(SIG_WREADY, 1'b1, "weight_ready high");
        for (int k = 0; k < nk; k++) begin
            send_weight(wt_set[k]);
        end
        build_expected(rows, cols, nk, relu);
        fetch0 = fetch_rises;
        full0 = full_cycles;
        pix_in = 0;
        res_out = 0;
        cur_nk = nk;

        cfg.num_rows = DIM_WIDTH'(rows);
        cfg.num_cols = DIM_WIDTH'(cols);
        cfg.relu_en = relu;
        job_cfg = cfg;
        job_start = 1'b1;
        wait_for(SIG_ACCEPT, 1'b1, "job_accept high");
        job_start = 1'b0;
        wait_for(SIG_ACCEPT, 1'b0, "job_accept low");
        if (stress) begin
            rand_ready = 1'b1;
            hold_until = $time + 3000;
        end

        for (int r = 0; r < rows; r++) begin
            // Variable fetch latency
            step($urandom % 4);
            wait_for(SIG_FETCH, 1'b1, "job_fetch_request high");
            job_fetch_ack = 1'b1;
            wait_for(SIG_FETCH, 1'b0, "job_fetch_request low");
            job_fetch_ack = 1'b0;
            for (int c = 0; c < cols; c++) begin
                send_pixel(pix_mem[r][c], stress);
            end
            pixel_valid = 1'b0;
        end

        wait_for(SIG_COMPLETE, 1'b1, "job_complete high");
        if (exp_q.size() != 0) begin
            $display("t=%0t job ended with %0d results never seen", $time, exp_q.size());
            errors++;
            exp_q.delete();
        end
        job_complete_ack = 1'b1;
        wait_for(SIG_COMPLETE, 1'b0, "job_complete low");
        job_complete_ack = 1'b0;
        rand_ready = 1'b0;
        wait_for(SIG_WREADY, 1'b1, "return to idle");

        if (fetch_rises - fetch0 != rows) begin
            $display("%s saw %0d fetch requests for %0d rows", name, fetch_rises - fetch0, rows);
            errors++;
        end
        if (stress && full_cycles == full0) begin
            $display("%s never filled the prefetch FIFO during the stall", name);
            errors++;
        end
        tests_run++;
        $display("%s: %0d results checked, %0d errors", name, checked - chk0, errors - err0);
    endtask

    initial begin
        void'($urandom(SEED));
        clk_core = 1'b0;
        rst = 1'b1;
        job_start = 1'b0;
        job_cfg = '0;
        job_fetch_ack = 1'b0;
        job_complete_ack = 1'b0;
        pixel_valid = 1'b0;
        pixel_data = '0;
        weight_valid = 1'b0;
        weight_data = '0;
        rand_ready = 1'b0;
        timed_out = 1'b0;
        hold_until = 0;
        pix_in = 0;
        res_out = 0;
        cur_nk = 1;

        repeat (8) @(posedge clk_core);
        #2;
        rst = 1'b0;

        @(negedge clk_core);
        check_bit("job_accept", job_accept, 1'b0);
        check_bit("job_fetch_request", job_fetch_request, 1'b0);
        check_bit("job_complete", job_complete, 1'b0);
        check_bit("result_valid", result_valid, 1'b0);
        check_bit("pixel_ready", pixel_ready, 1'b0);
        check_bit("weight_ready", weight_ready, 1'b1);
        tests_run++;
        $display("reset_state: %0d errors", errors);
        step(1);

        run_job("basic_job", 2, 3, 2, 1'b0, 1'b0, 1'b0);
        run_job("relu", 2, 4, 1, 1'b1, 1'b1, 1'b0);
        run_job("back_pressure", 4, 10, 4, 1'b0, 1'b0, 1'b1);
        run_job("reload", 3, 5, 3, 1'b0, 1'b0, 1'b0);

        $display("Done: %0d tests, %0d results checked, %0d errors", tests_run, checked, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
